/* verilog.f */
design/bpu_pkg.sv
design/inst_decode.sv
design/bimodal_table.sv
design/btb.sv
design/ras.sv
design/target_select.sv
design/bpu_top.sv
tests/bpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= bpu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* tests/bpu_tb.sv */
`timescale 1ns/1ps

module bpu_tb;
    import bpu_pkg::*;

    localparam int              RST_CYCLES  = 8;
    localparam int              RST_TIMEOUT = 50;   // cycles allowed for reset release
    localparam logic [XLEN-1:0] NOP         = 32'h0000_0013; // addi x0, x0, 0

    // one cycle of stimulus and the prediction expected in that cycle
    typedef struct packed {
        logic [XLEN-1:0] if_pc;
        logic [XLEN-1:0] if_inst;
        logic            ex_valid;
        logic            ex_taken;
        logic [XLEN-1:0] ex_pc;
        logic [XLEN-1:0] ex_target;
        logic [XLEN-1:0] ex_inst;
        logic            ex_stall;
        logic            push;
        logic [XLEN-1:0] push_addr;
        logic            id_stall;
        logic            exp_branch;
        logic            exp_taken;
        logic [XLEN-1:0] exp_pc;
    } row_t;

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] if_pc;
    logic [XLEN-1:0] if_inst;
    logic            ex_branch_valid;
    logic            ex_branch_taken;
    logic [XLEN-1:0] ex_pc;
    logic [XLEN-1:0] ex_target;
    logic [XLEN-1:0] ex_inst;
    logic            ex_stall;
    logic            id_ras_push;
    logic [XLEN-1:0] id_ras_push_addr;
    logic            id_stall;
    logic            branch;
    logic            pdt_taken;
    logic [XLEN-1:0] pdt_pc;

    row_t            rows[$];
    row_t            cur;           // row under construction
    int              row_idx;
    logic [XLEN-1:0] br_fwd;
    logic [XLEN-1:0] br_neg;
    logic [XLEN-1:0] jal_fwd;
    logic [XLEN-1:0] jalr_ind;
    logic [XLEN-1:0] inst_ret;

    bpu_top bpu_top_inst (
        .clk                (clk),
        .rst                (rst),
        .if_pc_i            (if_pc),
        .if_inst_i          (if_inst),
        .ex_branch_valid_i  (ex_branch_valid),
        .ex_branch_taken_i  (ex_branch_taken),
        .ex_pc_i            (ex_pc),
        .ex_target_i        (ex_target),
        .ex_inst_i          (ex_inst),
        .ex_stall_i         (ex_stall),
        .id_ras_push_i      (id_ras_push),
        .id_ras_push_addr_i (id_ras_push_addr),
        .id_stall_i         (id_stall),
        .branch_o           (branch),
        .pdt_taken_o        (pdt_taken),
        .pdt_pc_o           (pdt_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

    // bne x10, x11, off
    function automatic logic [XLEN-1:0] enc_branch(input logic [12:0] off);
        inst_word_u w;
        w           = '0;
        w.b.opcode  = OP_BRANCH;
        w.b.funct3  = 3'b001;
        w.b.rs1     = 5'd10;
        w.b.rs2     = 5'd11;
        w.b.imm12   = off[12];
        w.b.imm11   = off[11];
        w.b.imm10_5 = off[10:5];
        w.b.imm4_1  = off[4:1];
        return w;
    endfunction

    // jal ra, off
    function automatic logic [XLEN-1:0] enc_jal(input logic [20:0] off);
        inst_word_u w;
        w            = '0;
        w.j.opcode   = OP_JAL;
        w.j.rd       = REG_RA;
        w.j.imm20    = off[20];
        w.j.imm19_12 = off[19:12];
        w.j.imm11    = off[11];
        w.j.imm10_1  = off[10:1];
        return w;
    endfunction

    // jalr rd, 0(rs1)
    function automatic logic [XLEN-1:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        inst_word_u w;
        w          = '0;
        w.b.opcode = OP_JALR;
        w.b.rs1    = rs1;
        w.j.rd     = rd;    // rd overlays imm4_1 and imm11 of the b view
        return w;
    endfunction

    task automatic clear_row();
        cur         = '0;
        cur.if_inst = NOP;
    endtask

    task automatic fetch_at(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] inst);
        cur.if_pc   = pc;
        cur.if_inst = inst;
    endtask

    task automatic feedback(input logic taken, input logic [XLEN-1:0] pc,
                            input logic [XLEN-1:0] target, input logic [XLEN-1:0] inst);
        cur.ex_valid  = 1'b1;
        cur.ex_taken  = taken;
        cur.ex_pc     = pc;
        cur.ex_target = target;
        cur.ex_inst   = inst;
    endtask

    task automatic call_push(input logic [XLEN-1:0] addr);
        cur.push      = 1'b1;
        cur.push_addr = addr;
    endtask

    task automatic stalls(input logic id_s, input logic ex_s);
        cur.id_stall = id_s;
        cur.ex_stall = ex_s;
    endtask

    // closes the row under construction
    task automatic expect_pred(input logic br, input logic tk, input logic [XLEN-1:0] pc);
        cur.exp_branch = br;
        cur.exp_taken  = tk;
        cur.exp_pc     = pc;
        rows.push_back(cur);
        clear_row();
    endtask

    task automatic build_table();
        br_fwd   = enc_branch(13'h0040);
        br_neg   = enc_branch(13'h1fe0);     // -32
        jal_fwd  = enc_jal(21'h000800);
        jalr_ind = enc_jalr(REG_RA, 5'd6);   // indirect call, not a return
        inst_ret = enc_jalr(5'd0, REG_RA);
        clear_row();
        // fresh state
        fetch_at(32'h0000_1000, NOP);
        expect_pred(1'b0, 1'b0, 32'h0000_1004);
        fetch_at(32'h0000_1100, br_fwd);
        expect_pred(1'b1, 1'b0, 32'h0000_1104);
        fetch_at(32'h0000_1200, jal_fwd);
        expect_pred(1'b1, 1'b1, 32'h0000_1a00);
        // counter 01 -> 10 -> 01 -> 00 -> 00 -> 01
        fetch_at(32'h0000_1300, NOP);
        feedback(1'b1, 32'h0000_2040, 32'h0000_3000, br_neg);
        expect_pred(1'b0, 1'b0, 32'h0000_1304);
        fetch_at(32'h0000_2040, br_neg);
        feedback(1'b0, 32'h0000_2040, 32'h0000_2044, br_neg);
        expect_pred(1'b1, 1'b1, 32'h0000_3000);
        fetch_at(32'h0000_2040, br_neg);
        feedback(1'b0, 32'h0000_2040, 32'h0000_2044, br_neg);
        expect_pred(1'b1, 1'b0, 32'h0000_2044);
        fetch_at(32'h0000_2040, br_neg);
        feedback(1'b0, 32'h0000_2040, 32'h0000_2044, br_neg);
        expect_pred(1'b1, 1'b0, 32'h0000_2044);
        fetch_at(32'h0000_2040, br_neg);
        feedback(1'b1, 32'h0000_2040, 32'h0000_3000, br_neg);
        expect_pred(1'b1, 1'b0, 32'h0000_2044);
        // same counter index and btb index, different tag
        fetch_at(32'h0000_2040, br_neg);
        feedback(1'b1, 32'h0000_a040, 32'h0000_3300, br_neg);
        expect_pred(1'b1, 1'b0, 32'h0000_2044);
        fetch_at(32'h0000_b040, br_neg);
        expect_pred(1'b1, 1'b1, 32'h0000_b020);
        // indirect jump through the btb
        fetch_at(32'h0000_4080, jalr_ind);
        feedback(1'b1, 32'h0000_4080, 32'h0000_5550, jalr_ind);
        expect_pred(1'b1, 1'b0, 32'h0000_4084);
        fetch_at(32'h0000_4080, jalr_ind);
        expect_pred(1'b1, 1'b1, 32'h0000_5550);
        fetch_at(32'h0000_8080, jalr_ind);
        expect_pred(1'b1, 1'b0, 32'h0000_8084);
        // stack order
        fetch_at(32'h0000_1300, NOP);
        call_push(32'h0000_6004);
        expect_pred(1'b0, 1'b0, 32'h0000_1304);
        fetch_at(32'h0000_1300, NOP);
        call_push(32'h0000_7008);
        expect_pred(1'b0, 1'b0, 32'h0000_1304);
        fetch_at(32'h0000_9000, inst_ret);
        feedback(1'b1, 32'h0000_9000, 32'h0000_7008, inst_ret);
        expect_pred(1'b1, 1'b1, 32'h0000_7008);
        fetch_at(32'h0000_9000, inst_ret);
        feedback(1'b1, 32'h0000_9000, 32'h0000_6004, inst_ret);
        expect_pred(1'b1, 1'b1, 32'h0000_6004);
        fetch_at(32'h0000_9000, inst_ret);
        expect_pred(1'b1, 1'b0, 32'h0000_9004);
        fetch_at(32'h0000_9000, inst_ret);
        call_push(32'h0000_6104);           // bypass to the return in fetch
        expect_pred(1'b1, 1'b1, 32'h0000_6104);
        fetch_at(32'h0000_9000, inst_ret);
        expect_pred(1'b1, 1'b1, 32'h0000_6104);
        // stalled pushes and pops leave the stack alone
        fetch_at(32'h0000_1300, NOP);
        call_push(32'h0000_6200);
        stalls(1'b1, 1'b0);
        expect_pred(1'b0, 1'b0, 32'h0000_1304);
        fetch_at(32'h0000_1300, NOP);
        call_push(32'h0000_6300);
        stalls(1'b0, 1'b1);
        expect_pred(1'b0, 1'b0, 32'h0000_1304);
        fetch_at(32'h0000_9000, inst_ret);
        feedback(1'b1, 32'h0000_9000, 32'h0000_6104, inst_ret);
        stalls(1'b0, 1'b1);
        expect_pred(1'b1, 1'b1, 32'h0000_6104);
        fetch_at(32'h0000_9000, inst_ret);
        feedback(1'b1, 32'h0000_9000, 32'h0000_6104, inst_ret);
        expect_pred(1'b1, 1'b1, 32'h0000_6104);
        fetch_at(32'h0000_9000, inst_ret);
        expect_pred(1'b1, 1'b0, 32'h0000_9004);
    endtask

    task automatic drive_row(input row_t r);
        if_pc            = r.if_pc;
        if_inst          = r.if_inst;
        ex_branch_valid  = r.ex_valid;
        ex_branch_taken  = r.ex_taken;
        ex_pc            = r.ex_pc;
        ex_target        = r.ex_target;
        ex_inst          = r.ex_inst;
        ex_stall         = r.ex_stall;
        id_ras_push      = r.push;
        id_ras_push_addr = r.push_addr;
        id_stall         = r.id_stall;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t row %0d %s got %b expected %b",
                     $time, row_idx, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "prediction mismatch");
        end
    endtask

    task automatic check_addr(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t row %0d %s got %h expected %h",
                     $time, row_idx, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "prediction mismatch");
        end
    endtask

    initial begin
        int waited;
        row_idx = 0;
        clear_row();
        drive_row(cur);     // all inputs idle from time zero
        build_table();
        waited = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > RST_TIMEOUT) begin
                $display("reset was not released within %0d cycles", RST_TIMEOUT);
                $display("*** FAILED ***");
                $fatal(1, "reset timeout");
            end
        end
        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            @(posedge clk);
            #1 drive_row(rows[row_idx]);
            #4;     // mid cycle, outputs settled
            check_bit("branch_o", branch, rows[row_idx].exp_branch);
            check_bit("pdt_taken_o", pdt_taken, rows[row_idx].exp_taken);
            check_addr("pdt_pc_o", pdt_pc, rows[row_idx].exp_pc);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* design/bpu_top.sv */
`timescale 1ns/1ps

module bpu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] if_inst_i,
    input  logic                     ex_branch_valid_i,
    input  logic                     ex_branch_taken_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_target_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_inst_i,
    input  logic                     ex_stall_i,
    input  logic                     id_ras_push_i,
    input  logic [bpu_pkg::XLEN-1:0] id_ras_push_addr_i,
    input  logic                     id_stall_i,
    output logic                     branch_o,
    output logic                     pdt_taken_o,
    output logic [bpu_pkg::XLEN-1:0] pdt_pc_o
);
    import bpu_pkg::*;

    logic            if_is_branch, if_is_jal, if_is_jalr, if_is_ret;
    logic [XLEN-1:0] if_b_off, if_j_off;
    logic            ex_is_ret;
    logic            bm_taken;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic            ras_valid;
    logic [XLEN-1:0] ras_addr;

    inst_decode if_dec_inst (.inst_i(if_inst_i), .is_branch_o(if_is_branch),
        .is_jal_o(if_is_jal), .is_jalr_o(if_is_jalr), .is_ret_o(if_is_ret),
        .b_off_o(if_b_off), .j_off_o(if_j_off));

    // execute copy, return flag only
    inst_decode ex_dec_inst (.inst_i(ex_inst_i), .is_branch_o(), .is_jal_o(),
        .is_jalr_o(), .is_ret_o(ex_is_ret), .b_off_o(), .j_off_o());

    bimodal_table bimodal_table_inst (.clk(clk), .rst(rst), .if_pc_i(if_pc_i),
        .ex_valid_i(ex_branch_valid_i), .ex_taken_i(ex_branch_taken_i),
        .ex_pc_i(ex_pc_i), .pred_taken_o(bm_taken));

    btb btb_inst (.clk(clk), .rst(rst), .if_pc_i(if_pc_i),
        .ex_valid_i(ex_branch_valid_i), .ex_taken_i(ex_branch_taken_i),
        .ex_pc_i(ex_pc_i), .ex_target_i(ex_target_i),
        .hit_o(btb_hit), .target_o(btb_target));

    ras ras_inst (.clk(clk), .rst(rst), .ex_valid_i(ex_branch_valid_i),
        .ex_taken_i(ex_branch_taken_i), .ex_is_ret_i(ex_is_ret), .ex_stall_i(ex_stall_i),
        .id_push_i(id_ras_push_i), .id_push_addr_i(id_ras_push_addr_i),
        .id_stall_i(id_stall_i), .top_valid_o(ras_valid), .top_addr_o(ras_addr));

    target_select target_select_inst (.if_pc_i(if_pc_i), .is_branch_i(if_is_branch),
        .is_jal_i(if_is_jal), .is_jalr_i(if_is_jalr), .is_ret_i(if_is_ret),
        .b_off_i(if_b_off), .j_off_i(if_j_off), .bm_taken_i(bm_taken),
        .btb_hit_i(btb_hit), .btb_target_i(btb_target), .ras_valid_i(ras_valid),
        .ras_addr_i(ras_addr), .branch_o(branch_o), .pdt_taken_o(pdt_taken_o),
        .pdt_pc_o(pdt_pc_o));

endmodule

/* design/target_select.sv */
`timescale 1ns/1ps

module target_select (
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    input  logic                     is_branch_i,
    input  logic                     is_jal_i,
    input  logic                     is_jalr_i,
    input  logic                     is_ret_i,
    input  logic [bpu_pkg::XLEN-1:0] b_off_i,
    input  logic [bpu_pkg::XLEN-1:0] j_off_i,
    input  logic                     bm_taken_i,
    input  logic                     btb_hit_i,
    input  logic [bpu_pkg::XLEN-1:0] btb_target_i,
    input  logic                     ras_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] ras_addr_i,
    output logic                     branch_o,
    output logic                     pdt_taken_o,
    output logic [bpu_pkg::XLEN-1:0] pdt_pc_o
);
    import bpu_pkg::*;

    logic [XLEN-1:0] pc_plus4;

    assign pc_plus4 = if_pc_i + XLEN'(4);
    assign branch_o = is_branch_i || is_jal_i || is_jalr_i;

    always_comb begin
        pdt_taken_o = 1'b0;     // fall through by default
        pdt_pc_o    = pc_plus4;
        if (is_ret_i) begin
            if (ras_valid_i) begin
                pdt_taken_o = 1'b1;
                pdt_pc_o    = ras_addr_i;
            end
        end else if (is_jal_i) begin
            pdt_taken_o = 1'b1; // unconditional
            pdt_pc_o    = btb_hit_i ? btb_target_i : if_pc_i + j_off_i;
        end else if (is_jalr_i) begin
            if (btb_hit_i) begin    // indirect, btb only
                pdt_taken_o = 1'b1;
                pdt_pc_o    = btb_target_i;
            end
        end else if (is_branch_i && bm_taken_i) begin
            pdt_taken_o = 1'b1;
            pdt_pc_o    = btb_hit_i ? btb_target_i : if_pc_i + b_off_i;
        end
    end

    // return flag comes from decode, must imply a jalr
    always_comb begin
        assert final (!pdt_taken_o || branch_o)
            else $error("target_select: taken prediction on a non-branch");
    end

endmodule

/* design/ras.sv */
`timescale 1ns/1ps

module ras (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ex_valid_i,
    input  logic                     ex_taken_i,
    input  logic                     ex_is_ret_i,
    input  logic                     ex_stall_i,
    input  logic                     id_push_i,
    input  logic [bpu_pkg::XLEN-1:0] id_push_addr_i,
    input  logic                     id_stall_i,
    output logic                     top_valid_o,
    output logic [bpu_pkg::XLEN-1:0] top_addr_o
);
    import bpu_pkg::*;

    localparam int IDX_W = RAS_PTR_W - 1;

    logic [XLEN-1:0]      stack_q [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] ptr_q;      // next free slot
    logic [RAS_PTR_W-1:0] ptr_pop;    // pointer after this cycle's pop
    logic [RAS_PTR_W-1:0] ptr_d;
    logic [RAS_PTR_W-1:0] top_ptr;
    logic                 do_pop;
    logic                 do_push;
    logic                 full_after_pop;

    // taken return resolved in execute
    assign do_pop = ex_valid_i && ex_taken_i && ex_is_ret_i && !ex_stall_i
                    && (ptr_q != '0);
    assign ptr_pop = do_pop ? ptr_q - 1'b1 : ptr_q;

    assign full_after_pop = (ptr_pop == RAS_PTR_W'(RAS_DEPTH));

    // call seen in decode, dropped when full
    assign do_push = id_push_i && !id_stall_i && !ex_stall_i && !full_after_pop;
    assign ptr_d   = do_push ? ptr_pop + 1'b1 : ptr_pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
        end else begin
            ptr_q <= ptr_d;
        end
    end

    // push lands on the slot freed by a same-cycle pop
    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[ptr_pop[IDX_W-1:0]] <= id_push_addr_i;
        end
    end

    assign top_ptr = ptr_q - 1'b1; // wraps at empty, masked by valid

    // a call in decode this cycle shadows the stored top
    assign top_valid_o = id_push_i || (ptr_q != '0);
    assign top_addr_o  = id_push_i ? id_push_addr_i : stack_q[top_ptr[IDX_W-1:0]];

    // pop and push guards together keep the pointer in range
    assert property (@(posedge clk) disable iff (rst) ptr_q <= RAS_PTR_W'(RAS_DEPTH))
        else $error("ras: pointer beyond stack depth");

endmodule

/* design/btb.sv */
`timescale 1ns/1ps

module btb (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    input  logic                     ex_valid_i,
    input  logic                     ex_taken_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_target_i,
    output logic                     hit_o,
    output logic [bpu_pkg::XLEN-1:0] target_o
);
    import bpu_pkg::*;

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [BTB_TAG_W-1:0]   tag_q    [BTB_ENTRIES];
    logic [XLEN-1:0]        target_q [BTB_ENTRIES];

    logic [BTB_INDEX_W-1:0] rd_idx;
    logic [BTB_TAG_W-1:0]   rd_tag;
    logic [BTB_INDEX_W-1:0] wr_idx;
    logic [BTB_TAG_W-1:0]   wr_tag;
    logic                   wr_en;

    // word index pc[9:2], tag is everything above
    assign rd_idx = if_pc_i[BTB_INDEX_W+1:2];
    assign rd_tag = if_pc_i[XLEN-1:XLEN-BTB_TAG_W];
    assign wr_idx = ex_pc_i[BTB_INDEX_W+1:2];
    assign wr_tag = ex_pc_i[XLEN-1:XLEN-BTB_TAG_W];

    assign wr_en = ex_valid_i && ex_taken_i; // only taken transfers allocate

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= ex_target_i;
        end
    end

endmodule

/* design/bimodal_table.sv */
`timescale 1ns/1ps

module bimodal_table (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    input  logic                     ex_valid_i,
    input  logic                     ex_taken_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_pc_i,
    output logic                     pred_taken_o
);
    import bpu_pkg::*;

    logic [1:0]            ctr_q [BM_ENTRIES];
    logic [BM_INDEX_W-1:0] rd_idx;
    logic [BM_INDEX_W-1:0] wr_idx;
    logic [1:0]            wr_ctr;

    // halfword aligned index, pc[9:1]
    assign rd_idx = if_pc_i[BM_INDEX_W:1];
    assign wr_idx = ex_pc_i[BM_INDEX_W:1];
    assign wr_ctr = ctr_q[wr_idx];

    assign pred_taken_o = ctr_q[rd_idx][1]; // msb gives direction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BM_ENTRIES; i++) begin
                ctr_q[i] <= CTR_WEAK_NT;
            end
        end else if (ex_valid_i) begin
            if (ex_taken_i) begin
                if (wr_ctr != 2'b11) begin
                    ctr_q[wr_idx] <= wr_ctr + 2'd1;
                end
            end else begin
                if (wr_ctr != 2'b00) begin
                    ctr_q[wr_idx] <= wr_ctr - 2'd1;
                end
            end
        end
    end

endmodule

/* design/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  bpu_pkg::inst_word_u        inst_i,
    output logic                       is_branch_o,
    output logic                       is_jal_o,
    output logic                       is_jalr_o,
    output logic                       is_ret_o,
    output logic [bpu_pkg::XLEN-1:0]   b_off_o,
    output logic [bpu_pkg::XLEN-1:0]   j_off_o
);
    import bpu_pkg::*;

    logic       link_rs1;   // rs1 is ra or t0
    logic       imm_zero;   // i-type immediate is zero
    logic [4:0] rd;
    logic [4:0] rs1;

    assign rd  = inst_i.j.rd;
    assign rs1 = inst_i.b.rs1;

    assign is_branch_o = (inst_i.b.opcode == OP_BRANCH);
    assign is_jal_o    = (inst_i.j.opcode == OP_JAL);
    assign is_jalr_o   = (inst_i.j.opcode == OP_JALR);

    // i-type imm[11:0] overlays imm12, imm10_5 and rs2 of the b view
    assign imm_zero = ~inst_i.b.imm12 && (inst_i.b.imm10_5 == 6'd0) && (inst_i.b.rs2 == 5'd0);
    assign link_rs1 = (rs1 == REG_RA) || (rs1 == REG_T0);

    // same return rule for fetch and execute
    assign is_ret_o = is_jalr_o && (rd == 5'd0) && link_rs1 && imm_zero;

    assign b_off_o = {{(XLEN-13){inst_i.b.imm12}},
                      inst_i.b.imm12,
                      inst_i.b.imm11,
                      inst_i.b.imm10_5,
                      inst_i.b.imm4_1,
                      1'b0};

    assign j_off_o = {{(XLEN-21){inst_i.j.imm20}},
                      inst_i.j.imm20,
                      inst_i.j.imm19_12,
                      inst_i.j.imm11,
                      inst_i.j.imm10_1,
                      1'b0};

endmodule

/* design/bpu_pkg.sv */
package bpu_pkg;

    // datapath width
    localparam int XLEN = 32;

    // bimodal direction table, indexed by pc[9:1]
    localparam int BM_ENTRIES = 512;
    localparam int BM_INDEX_W = 9;

    // branch target buffer, indexed by pc[9:2], tagged by pc[31:10]
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_INDEX_W = 8;
    localparam int BTB_TAG_W   = 22;

    // return address stack; one extra pointer bit so that 64 means full
    localparam int RAS_DEPTH = 64;
    localparam int RAS_PTR_W = 7;

    localparam logic [1:0] CTR_WEAK_NT = 2'b01; // weakly not-taken

    // rv32 control-transfer opcodes
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // link registers for call / return detection
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // jal layout, rd also sits here for jalr
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // same word, immediates scattered differently per format
    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
    } inst_word_u;

endpackage
